// ==== bench/uma_sva.sv ====
/* Concurrent checks on the primary RAM port and the slot pulses,
   bound into the arbiter top */
`timescale 1ns/1ps

module uma_sva (
    input logic CLK,
    input logic RESET_n,
    input logic slot_main,
    input logic slot_video,
    input logic prim_oe_n,
    input logic prim_we_n,
    input logic prim_rfsh_n,
    input logic prim_ack_n
);
    // One access on the shared port at a time
    a_one_strobe: assert property (@(posedge CLK) disable iff (!RESET_n)
        $onehot0({!prim_oe_n, !prim_we_n, !prim_rfsh_n}))
        else $error("more than one primary strobe low");

    a_slot_excl: assert property (@(posedge CLK) disable iff (!RESET_n)
        !(slot_main && slot_video))
        else $error("main and video slot pulses together");

    // Strobes released right after the RAM acknowledges
    a_release: assert property (@(posedge CLK) disable iff (!RESET_n)
        !prim_ack_n |=> (prim_oe_n && prim_we_n))
        else $error("primary strobe still low after ack");

endmodule

bind uma_top uma_sva sva_i (
    .CLK(CLK),
    .RESET_n(RESET_n),
    .slot_main(slot_main),
    .slot_video(slot_video),
    .prim_oe_n(prim_oe_n),
    .prim_we_n(prim_we_n),
    .prim_rfsh_n(prim_rfsh_n),
    .prim_ack_n(prim_ack_n)
);

// ==== bench/uma_tb.sv ====
/* Arbiter testbench with clock and reset, RAM model, client stimulus,
   shadow memory reference and response compare */
`timescale 1ns/1ps

module uma_tb
    import uma_pkg::*;
();
    localparam logic [1:0] K_READ  = 2'd0;
    localparam logic [1:0] K_WRITE = 2'd1;
    localparam logic [1:0] K_RFSH  = 2'd2;
    localparam int N_RANDOM = 40;
    localparam int MAX_CYCLES = 60 * 90 + 600;  // About 60 accesses of at most 90 clocks

    typedef struct packed {
        logic [1:0] kind;
        uma_addr_t  addr;       // Expected physical address
        uma_data_t  data;       // Expected read or write data
    } exp_t;

    logic       CLK = 1'b0;
    logic       RESET_n = 1'b0;
    logic       clk_en = 1'b0;
    logic       oe_n_main, we_n_main, rfsh_n_main, ack_n_main;
    logic       oe_n_video, we_n_video, rfsh_n_video, ack_n_video;
    uma_addr_t  addr_main, addr_video, base_main, base_video;
    uma_data_t  din_main, din_video, dout_main, dout_video;
    uma_addr_t  prim_addr;
    uma_data_t  prim_din;
    uma_data_t  prim_dout = '0;
    logic       prim_oe_n, prim_we_n, prim_rfsh_n;
    logic       prim_ack_n = 1'b1;

    logic [4:0] en_cnt;
    logic [1:0] ram_cnt;
    logic       ram_sel, ram_sel_q;
    uma_addr_t  ram_last_addr;
    uma_data_t  ram_last_din;
    logic [1:0] ram_last_kind;
    uma_data_t  ram [uma_addr_t];
    uma_data_t  shadow [uma_addr_t];     // Reference copy of physical memory
    exp_t       exp_q_main[$];
    exp_t       exp_q_video[$];
    logic       ack_prev_main = 1'b1;
    logic       ack_prev_video = 1'b1;
    int         cycle_cnt = 0;
    integer     seed;

    uma_top dut_i (.*);

    always #20 CLK = ~CLK;

    // CPU clock enable every 30 clocks
    always @(posedge CLK) begin
        if (!RESET_n) begin
            en_cnt <= 5'd0;
            clk_en <= 1'b0;
        end else begin
            en_cnt <= (en_cnt == 5'd29) ? 5'd0 : en_cnt + 5'd1;
            clk_en <= (en_cnt == 5'd29);
        end
    end

    // Shared RAM model answering 3 clocks after a strobe falls
    assign ram_sel = !prim_oe_n || !prim_we_n || !prim_rfsh_n;

    always @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            prim_ack_n    <= 1'b1;
            prim_dout     <= '0;
            ram_cnt       <= 2'd0;
            ram_sel_q     <= 1'b0;
            ram_last_addr <= '0;
            ram_last_din  <= '0;
            ram_last_kind <= K_READ;
        end else begin
            ram_sel_q  <= ram_sel;
            prim_ack_n <= 1'b1;
            if (ram_sel && !ram_sel_q) begin
                ram_cnt <= 2'd1;
            end else if (ram_cnt == 2'd2) begin
                ram_cnt       <= 2'd0;
                prim_ack_n    <= 1'b0;
                ram_last_addr <= prim_addr;
                if (!prim_we_n) begin
                    ram[prim_addr] = prim_din;
                    ram_last_din  <= prim_din;
                    ram_last_kind <= K_WRITE;
                end else if (!prim_oe_n) begin
                    prim_dout     <= ram.exists(prim_addr) ? ram[prim_addr] : '0;
                    ram_last_kind <= K_READ;
                end else begin
                    ram_last_kind <= K_RFSH;    // Memory untouched
                end
            end else if (ram_cnt != 2'd0) begin
                ram_cnt <= ram_cnt + 2'd1;
            end
        end
    end

    task automatic stop_failed();
        $display("Verification failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic abort_run(input string why);
        $display("ERROR at %0t: %s", $time, why);
        stop_failed();
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            stop_failed();
        end
    endtask

    always @(posedge CLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) abort_run("timeout, accesses did not complete in time");
    end

    // Local address plus channel base modulo 2^24
    function automatic uma_addr_t phys_addr(input uma_chan_t ch, input uma_addr_t laddr);
        return laddr + ((ch == CH_MAIN) ? base_main : base_video);
    endfunction

    function automatic uma_data_t expected_read(input uma_chan_t ch, input uma_addr_t laddr);
        uma_addr_t pa;
        pa = phys_addr(ch, laddr);
        return shadow.exists(pa) ? shadow[pa] : '0;
    endfunction

    function automatic logic ack_of(input uma_chan_t ch);
        return (ch == CH_MAIN) ? ack_n_main : ack_n_video;
    endfunction

    // Compare each completed access against its expected record
    task automatic compare_done(input uma_chan_t ch);
        exp_t      e;
        uma_data_t got;
        string     nm;
        if ((ch == CH_MAIN && exp_q_main.size() == 0) ||
            (ch == CH_VIDEO && exp_q_video.size() == 0)) begin
            abort_run("ack_n rose with no access outstanding");
        end else begin
            if (ch == CH_MAIN) begin
                e   = exp_q_main.pop_front();
                got = dout_main;
                nm  = "dout_main";
            end else begin
                e   = exp_q_video.pop_front();
                got = dout_video;
                nm  = "dout_video";
            end
            check("prim strobe kind", 32'(ram_last_kind), 32'(e.kind));
            check("prim_addr", 32'(ram_last_addr), 32'(e.addr));
            if (e.kind == K_WRITE) check("prim_din", 32'(ram_last_din), 32'(e.data));
            if (e.kind == K_READ) check(nm, 32'(got), 32'(e.data));
        end
    endtask

    always @(negedge CLK) begin
        if (RESET_n) begin
            if (ack_n_main && !ack_prev_main) compare_done(CH_MAIN);
            if (ack_n_video && !ack_prev_video) compare_done(CH_VIDEO);
        end
        ack_prev_main  = ack_n_main;
        ack_prev_video = ack_n_video;
    end

    task automatic drive_strobe(input uma_chan_t ch, input logic [1:0] kind, input logic lvl,
                                input uma_addr_t laddr, input uma_data_t wdata);
        if (ch == CH_MAIN) begin
            addr_main   <= laddr;
            din_main    <= wdata;
            oe_n_main   <= (kind == K_READ) ? lvl : 1'b1;
            we_n_main   <= (kind == K_WRITE) ? lvl : 1'b1;
            rfsh_n_main <= (kind == K_RFSH) ? lvl : 1'b1;
        end else begin
            addr_video   <= laddr;
            din_video    <= wdata;
            oe_n_video   <= (kind == K_READ) ? lvl : 1'b1;
            we_n_video   <= (kind == K_WRITE) ? lvl : 1'b1;
            rfsh_n_video <= (kind == K_RFSH) ? lvl : 1'b1;
        end
    endtask

    // One client transaction as a strobe pulse and a wait for ack_n to rise
    task automatic access(input uma_chan_t ch, input logic [1:0] kind,
                          input uma_addr_t laddr, input uma_data_t wdata);
        exp_t e;
        e.kind = kind;
        e.addr = (kind == K_RFSH) ? '0 : phys_addr(ch, laddr);
        e.data = '0;
        if (kind == K_READ) e.data = expected_read(ch, laddr);
        else if (kind == K_WRITE) e.data = wdata;
        if (kind == K_WRITE) shadow[phys_addr(ch, laddr)] = wdata;
        if (ch == CH_MAIN) exp_q_main.push_back(e);
        else exp_q_video.push_back(e);
        @(posedge CLK);
        drive_strobe(ch, kind, 1'b0, laddr, wdata);
        @(posedge CLK);
        drive_strobe(ch, kind, 1'b1, laddr, wdata);
        @(negedge CLK);
        while (ack_of(ch)) @(negedge CLK);
        while (!ack_of(ch)) @(negedge CLK);
    endtask

    initial begin
        logic [31:0] rnd;
        uma_chan_t   ch;
        seed = 32'h11ee_e318;
        {oe_n_main, we_n_main, rfsh_n_main} = 3'b111;
        {oe_n_video, we_n_video, rfsh_n_video} = 3'b111;
        addr_main  = '0;
        addr_video = '0;
        din_main   = '0;
        din_video  = '0;
        base_main  = 24'h10_0000;
        base_video = 24'h20_0000;
        repeat (10) @(posedge CLK);
        RESET_n <= 1'b1;
        @(negedge CLK);
        check("ack_n_main", 32'(ack_n_main), 32'd1);
        check("ack_n_video", 32'(ack_n_video), 32'd1);
        check("prim strobes", 32'({prim_oe_n, prim_we_n, prim_rfsh_n}), 32'd7);
        check("dout_main", 32'(dout_main), 32'd0);
        check("dout_video", 32'(dout_video), 32'd0);
        access(CH_MAIN, K_WRITE, 24'h00_1234, 16'hA55A);
        access(CH_MAIN, K_READ, 24'h00_1234, '0);
        access(CH_MAIN, K_WRITE, 24'hFF_FFFF, 16'h1F2E);
        access(CH_MAIN, K_READ, 24'hFF_FFFF, '0);
        // Same physical word seen from both channels
        access(CH_MAIN, K_WRITE, 24'h30_0040 - base_main, 16'h5AA5);
        access(CH_VIDEO, K_READ, 24'h30_0040 - base_video, '0);
        access(CH_MAIN, K_WRITE, 24'h00_0000 - base_main, 16'hC3C3);
        access(CH_MAIN, K_RFSH, '0, '0);
        access(CH_VIDEO, K_RFSH, '0, '0);
        access(CH_VIDEO, K_READ, 24'h00_0000 - base_video, '0);
        fork
            access(CH_MAIN, K_READ, 24'h00_1234, '0);
            access(CH_VIDEO, K_READ, 24'h10_0040, '0);
        join
        @(posedge CLK);
        base_main  <= 24'hFF_FFF0;     // Bases that wrap
        base_video <= 24'h00_0010;
        @(posedge CLK);
        for (int i = 0; i < N_RANDOM; i++) begin
            rnd = $random(seed);
            ch  = uma_chan_t'(rnd[0]);
            access(ch, rnd[1] ? K_WRITE : K_READ, 24'hFF_FFE0 + 24'(rnd[7:2]), rnd[31:16]);
        end
        repeat (4) @(negedge CLK);
        if (exp_q_main.size() == 0 && exp_q_video.size() == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            abort_run("accesses left without a completed handshake");
        end
    end

endmodule

// ==== hdl/uma_chan_capture.sv ====
/* Client channel front end with strobe edge detection, request hold,
   slot delay, ack_n handshake and read data return */
`timescale 1ns/1ps
`include "uma_macros.svh"

module uma_chan_capture
    import uma_pkg::*;
#(
    parameter uma_chan_t CH = CH_MAIN
) (
    input  logic      CLK,
    input  logic      RESET_n,
    input  logic      oe_n,
    input  logic      we_n,
    input  logic      rfsh_n,
    input  uma_addr_t addr,
    input  uma_data_t din,
    input  uma_addr_t base,         // Physical offset of this channel
    input  logic      slot,         // Own slot pulse
    input  logic      slot_any,
    input  uma_data_t prim_dout,
    output uma_data_t dout,
    output logic      ack_n,
    output logic      issue,
    output logic      issue_oe,
    output logic      issue_we,
    output logic      issue_rfsh,
    output uma_addr_t issue_addr,
    output uma_data_t issue_din
);
    localparam int DLY = `UMA_EXEC_DELAY;

    logic           prev_oe_n;
    logic           prev_we_n;
    logic           prev_rfsh_n;
    logic           det_oe;
    logic           det_we;
    logic           det_rfsh;
    logic           det_any;
    logic           save_oe;
    logic           save_we;
    logic           save_rfsh;
    logic           req_oe;
    logic           req_we;
    logic           req_rfsh;
    logic           req_any;
    uma_addr_t      save_addr;
    uma_data_t      save_din;
    uma_addr_t      req_addr;
    uma_data_t      req_din;
    logic [DLY-1:0] slot_dly;
    logic           exec;
    logic           busy;
    logic           done;

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            prev_oe_n   <= 1'b1;
            prev_we_n   <= 1'b1;
            prev_rfsh_n <= 1'b1;
            slot_dly    <= '0;
        end else begin
            prev_oe_n   <= oe_n;
            prev_we_n   <= we_n;
            prev_rfsh_n <= rfsh_n;
            slot_dly    <= DLY'({slot_dly, slot});
        end
    end

    assign det_oe   = prev_oe_n && !oe_n;       // Falling edges
    assign det_we   = prev_we_n && !we_n;
    assign det_rfsh = prev_rfsh_n && !rfsh_n;
    assign det_any  = det_oe || det_we || det_rfsh;

    // A request is live from its edge until it is issued
    assign req_oe   = det_oe || save_oe;
    assign req_we   = det_we || save_we;
    assign req_rfsh = det_rfsh || save_rfsh;
    assign req_any  = req_oe || req_we || req_rfsh;

    // Address and data are taken straight from the pins on the edge cycle
    assign req_addr = (det_oe || det_we) ? addr : save_addr;
    assign req_din  = det_we ? din : save_din;

    assign exec  = slot_dly[DLY-1];
    assign issue = exec && req_any;
    assign done  = slot_any && busy;

    // One strobe per access, reads first and refresh last
    assign issue_oe   = req_oe;
    assign issue_we   = req_we && !req_oe;
    assign issue_rfsh = req_rfsh && !req_oe && !req_we;

    assign issue_addr = (issue_oe || issue_we) ? req_addr + base : '0;
    assign issue_din  = (issue_oe || issue_we) ? req_din : '0;

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            save_oe   <= 1'b0;
            save_we   <= 1'b0;
            save_rfsh <= 1'b0;
        end else begin
            if (issue && issue_oe) save_oe <= 1'b0;
            else if (det_oe) save_oe <= 1'b1;
            if (issue && issue_we) save_we <= 1'b0;
            else if (det_we) save_we <= 1'b1;
            if (issue && issue_rfsh) save_rfsh <= 1'b0;
            else if (det_rfsh) save_rfsh <= 1'b1;  // May queue behind a read or write
        end
    end

    always_ff @(posedge CLK) begin
        if (det_oe || det_we) save_addr <= addr;
        if (det_we) save_din <= din;
    end

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            busy  <= 1'b0;
            ack_n <= 1'b1;
        end else begin
            if (issue) busy <= 1'b1;
            else if (done) busy <= 1'b0;
            if (det_any) ack_n <= 1'b0;
            else if (done && !req_any) ack_n <= 1'b1;  // Stay low while more is queued
        end
    end

    // Read data register, named after its channel
    if (CH == CH_VIDEO) begin : g_vram_dout
        always_ff @(posedge CLK or negedge RESET_n) begin
            if (!RESET_n) dout <= '0;
            else if (done) dout <= prim_dout;
        end
    end else begin : g_mram_dout
        always_ff @(posedge CLK or negedge RESET_n) begin
            if (!RESET_n) dout <= '0;
            else if (done) dout <= prim_dout;
        end
    end

endmodule

// ==== hdl/uma_macros.svh ====
/* Width, slot timing and execution delay defines for the memory arbiter */
`ifndef UMA_MACROS_SVH
`define UMA_MACROS_SVH

// Physical and local address width
`define UMA_ADDR_W 24

// Data word width
`define UMA_DATA_W 16

// Divider period in system clocks per CPU clock
`define UMA_SLOT_DIV 30

// Slot pulse position after each slot boundary
`define UMA_SLOT_OFFSET 2

// Three slots per period
`define UMA_SLOT_SPACING 10

// Clocks from a slot pulse to the channel's execution point
`define UMA_EXEC_DELAY 2

`endif

// ==== hdl/uma_pkg.sv ====
/* Address, data and channel types shared by the arbiter blocks */
`include "uma_macros.svh"

package uma_pkg;

    // Local or physical RAM address
    typedef logic [`UMA_ADDR_W-1:0] uma_addr_t;

    // One RAM data word
    typedef logic [`UMA_DATA_W-1:0] uma_data_t;

    // Client channel select
    typedef enum logic {
        CH_MAIN  = 1'b0,    // Main RAM
        CH_VIDEO = 1'b1     // Video RAM
    } uma_chan_t;

endpackage

// ==== hdl/uma_primary_ctrl.sv ====
/* Primary RAM port FSM that runs one channel access at a time */
`timescale 1ns/1ps

module uma_primary_ctrl
    import uma_pkg::*;
(
    input  logic      CLK,
    input  logic      RESET_n,
    input  logic      issue_m,
    input  logic      oe_m,
    input  logic      we_m,
    input  logic      rfsh_m,
    input  uma_addr_t addr_m,
    input  uma_data_t din_m,
    input  logic      issue_v,
    input  logic      oe_v,
    input  logic      we_v,
    input  logic      rfsh_v,
    input  uma_addr_t addr_v,
    input  uma_data_t din_v,
    input  logic      prim_ack_n,
    output uma_addr_t prim_addr,
    output uma_data_t prim_din,
    output logic      prim_oe_n,
    output logic      prim_we_n,
    output logic      prim_rfsh_n
);
    typedef enum logic {
        IDLE,
        ACCESS
    } state_t;

    state_t state;
    logic   load_m;
    logic   load_v;

    // Main has priority, slots keep the two apart anyway
    assign load_m = (state == IDLE) && issue_m;
    assign load_v = (state == IDLE) && issue_v && !issue_m;

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            state       <= IDLE;
            prim_oe_n   <= 1'b1;
            prim_we_n   <= 1'b1;
            prim_rfsh_n <= 1'b1;
        end else begin
            case (state)
                IDLE: begin
                    if (load_m) begin
                        prim_oe_n   <= !oe_m;
                        prim_we_n   <= !we_m;
                        prim_rfsh_n <= !rfsh_m;
                        state       <= ACCESS;
                    end else if (load_v) begin
                        prim_oe_n   <= !oe_v;
                        prim_we_n   <= !we_v;
                        prim_rfsh_n <= !rfsh_v;
                        state       <= ACCESS;
                    end
                end
                ACCESS: begin
                    if (!prim_ack_n) begin      // RAM done, release strobes
                        prim_oe_n   <= 1'b1;
                        prim_we_n   <= 1'b1;
                        prim_rfsh_n <= 1'b1;
                        state       <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Address and write data launch together with the strobe
    always_ff @(posedge CLK) begin
        if (load_m) begin
            prim_addr <= addr_m;
            prim_din  <= din_m;
        end else if (load_v) begin
            prim_addr <= addr_v;
            prim_din  <= din_v;
        end
    end

endmodule

// ==== hdl/uma_slot_timer.sv ====
/* Slot timer with divider counter resynced on CLK_EN and
   alternating main and video slot pulses */
`timescale 1ns/1ps
`include "uma_macros.svh"

module uma_slot_timer
    import uma_pkg::*;
(
    input  logic CLK,
    input  logic RESET_n,
    input  logic clk_en,        // CPU clock enable
    output logic slot_main,
    output logic slot_video,
    output logic slot_any
);
    localparam int CNT_W = $clog2(`UMA_SLOT_DIV);

    typedef logic [CNT_W-1:0] cnt_t;

    localparam cnt_t CNT_LAST = cnt_t'(`UMA_SLOT_DIV - 1);
    localparam cnt_t SLOT_0   = cnt_t'(`UMA_SLOT_OFFSET);
    localparam cnt_t SLOT_1   = cnt_t'(`UMA_SLOT_OFFSET + `UMA_SLOT_SPACING);
    localparam cnt_t SLOT_2   = cnt_t'(`UMA_SLOT_OFFSET + 2 * `UMA_SLOT_SPACING);

    cnt_t      cnt;
    logic      slot_hit;
    uma_chan_t turn;            // Owner of the next slot

    // Divider restarts on every CPU clock enable
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            cnt <= '0;
        end else if (clk_en) begin
            cnt <= '0;
        end else if (cnt != CNT_LAST) begin
            cnt <= cnt + 1'b1;  // Holds at the last count
        end
    end

    assign slot_hit = (cnt == SLOT_0) || (cnt == SLOT_1) || (cnt == SLOT_2);

    // Registered slot pulses
    // The turn keeps toggling across periods
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            slot_main  <= 1'b0;
            slot_video <= 1'b0;
            slot_any   <= 1'b0;
            turn       <= CH_MAIN;
        end else begin
            slot_main  <= slot_hit && (turn == CH_MAIN);
            slot_video <= slot_hit && (turn == CH_VIDEO);
            slot_any   <= slot_hit;
            if (slot_hit) begin
                turn <= (turn == CH_MAIN) ? CH_VIDEO : CH_MAIN;
            end
        end
    end

endmodule

// ==== hdl/uma_top.sv ====
/* Memory arbiter top with slot timer, main and video channels
   and the primary RAM port controller */
`timescale 1ns/1ps

module uma_top
    import uma_pkg::*;
(
    input  logic      CLK,
    input  logic      RESET_n,
    input  logic      clk_en,
    // Main RAM client
    input  logic      oe_n_main,
    input  logic      we_n_main,
    input  logic      rfsh_n_main,
    input  uma_addr_t addr_main,
    input  uma_data_t din_main,
    output uma_data_t dout_main,
    output logic      ack_n_main,
    // Video RAM client
    input  logic      oe_n_video,
    input  logic      we_n_video,
    input  logic      rfsh_n_video,
    input  uma_addr_t addr_video,
    input  uma_data_t din_video,
    output uma_data_t dout_video,
    output logic      ack_n_video,
    input  uma_addr_t base_main,
    input  uma_addr_t base_video,
    // Shared physical RAM
    output uma_addr_t prim_addr,
    output uma_data_t prim_din,
    output logic      prim_oe_n,
    output logic      prim_we_n,
    output logic      prim_rfsh_n,
    input  uma_data_t prim_dout,
    input  logic      prim_ack_n
);
    logic      slot_main;
    logic      slot_video;
    logic      slot_any;
    logic      issue_m;
    logic      oe_m;
    logic      we_m;
    logic      rfsh_m;
    uma_addr_t addr_m;
    uma_data_t din_m;
    logic      issue_v;
    logic      oe_v;
    logic      we_v;
    logic      rfsh_v;
    uma_addr_t addr_v;
    uma_data_t din_v;

    uma_slot_timer timer_i (
        .CLK(CLK), .RESET_n(RESET_n), .clk_en(clk_en),
        .slot_main(slot_main), .slot_video(slot_video), .slot_any(slot_any)
    );

    uma_chan_capture #(.CH(CH_MAIN)) chan_main_i (
        .CLK(CLK), .RESET_n(RESET_n),
        .oe_n(oe_n_main), .we_n(we_n_main), .rfsh_n(rfsh_n_main),
        .addr(addr_main), .din(din_main), .base(base_main),
        .slot(slot_main), .slot_any(slot_any), .prim_dout(prim_dout),
        .dout(dout_main), .ack_n(ack_n_main),
        .issue(issue_m), .issue_oe(oe_m), .issue_we(we_m), .issue_rfsh(rfsh_m),
        .issue_addr(addr_m), .issue_din(din_m)
    );

    uma_chan_capture #(.CH(CH_VIDEO)) chan_video_i (
        .CLK(CLK), .RESET_n(RESET_n),
        .oe_n(oe_n_video), .we_n(we_n_video), .rfsh_n(rfsh_n_video),
        .addr(addr_video), .din(din_video), .base(base_video),
        .slot(slot_video), .slot_any(slot_any), .prim_dout(prim_dout),
        .dout(dout_video), .ack_n(ack_n_video),
        .issue(issue_v), .issue_oe(oe_v), .issue_we(we_v), .issue_rfsh(rfsh_v),
        .issue_addr(addr_v), .issue_din(din_v)
    );

    uma_primary_ctrl prim_i (
        .CLK(CLK), .RESET_n(RESET_n),
        .issue_m(issue_m), .oe_m(oe_m), .we_m(we_m), .rfsh_m(rfsh_m),
        .addr_m(addr_m), .din_m(din_m),
        .issue_v(issue_v), .oe_v(oe_v), .we_v(we_v), .rfsh_v(rfsh_v),
        .addr_v(addr_v), .din_v(din_v),
        .prim_ack_n(prim_ack_n), .prim_addr(prim_addr), .prim_din(prim_din),
        .prim_oe_n(prim_oe_n), .prim_we_n(prim_we_n), .prim_rfsh_n(prim_rfsh_n)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the arbiter testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module uma_tb -f vlog.f -o uma_sim

# Result is taken from the pass line in the simulation output
out=$(./obj_dir/uma_sim 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'Verification passed'

// ==== vlog.f ====
+incdir+hdl
hdl/uma_pkg.sv
hdl/uma_slot_timer.sv
hdl/uma_chan_capture.sv
hdl/uma_primary_ctrl.sv
hdl/uma_top.sv
bench/uma_sva.sv
bench/uma_tb.sv
